// File: Makefile
TOP = tbMipsLite

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	verilator --binary --assert --top-module $(TOP) -f build.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: build.f
+incdir+.
corePkg.sv
stageIf.sv
fetchUnit.sv
regFile.sv
decodeUnit.sv
divFsm.sv
divUnit.sv
executeUnit.sv
mipsLite.sv
tbMipsLite.sv

// File: corePkg.sv
package corePkg;

    // operation carried from decode into execute
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,   // also ADDIU
        OP_SUBU,
        OP_AND,
        OP_OR,     // also ORI
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_LUI,
        OP_MFHI,
        OP_MFLO,
        OP_DIVU
    } aluOp_t;

    // divider sequencing
    typedef enum logic {
        DIV_IDLE,
        DIV_BUSY
    } divState_t;

endpackage

// File: core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath word, also the address width
`define DATA_W 32

// register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// boot address of the program counter
`define RESET_PC 32'hBFC00000

// one quotient bit per step
`define DIV_STEPS 32

`endif

// File: decodeUnit.sv
`include "core_consts.svh"

module decodeUnit (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    stall_i,
    input  logic [`DATA_W-1:0]      instrD_i,
    input  logic [`DATA_W-1:0]      pcD_i,
    input  logic                    validD_i,
    input  logic [`DATA_W-1:0]      rdataA_i,
    input  logic [`DATA_W-1:0]      rdataB_i,
    output logic [`REG_ADDR_W-1:0]  raddrA_o,
    output logic [`REG_ADDR_W-1:0]  raddrB_o,
    input  logic                    exFwdValid_i,
    input  logic [`REG_ADDR_W-1:0]  exFwdReg_i,
    input  logic [`DATA_W-1:0]      exFwdData_i,
    wbBus.slave                     wb,
    deBus.master                    de
);
    import corePkg::*;

    logic [5:0]              opcode, funct;
    logic [`REG_ADDR_W-1:0]  rs, rt, rd, dest;
    aluOp_t                  op;
    logic                    writes, useImm, signExt;
    logic [`DATA_W-1:0]      imm, srcA, srcB;

    assign opcode = instrD_i[31:26];
    assign funct  = instrD_i[5:0];
    assign rs     = instrD_i[25:21];
    assign rt     = instrD_i[20:16];
    assign rd     = instrD_i[15:11];

    assign raddrA_o = rs;
    assign raddrB_o = rt;

    always_comb begin
        op      = OP_NOP;
        writes  = 1'b0;
        useImm  = 1'b0;
        signExt = 1'b0;
        dest    = rd;
        case (opcode)
            6'h00: begin  // SPECIAL, picked by funct
                writes = 1'b1;
                case (funct)
                    6'h00: op = OP_SLL;
                    6'h10: op = OP_MFHI;
                    6'h12: op = OP_MFLO;
                    6'h21: op = OP_ADDU;
                    6'h23: op = OP_SUBU;
                    6'h24: op = OP_AND;
                    6'h25: op = OP_OR;
                    6'h26: op = OP_XOR;
                    6'h2A: op = OP_SLT;
                    6'h1B: begin
                        op     = OP_DIVU;
                        writes = 1'b0;  // result lands in HI/LO only
                    end
                    default: writes = 1'b0;  // unknown funct is a NOP
                endcase
            end
            6'h09: begin op = OP_ADDU; writes = 1'b1; useImm = 1'b1; signExt = 1'b1; dest = rt; end
            6'h0D: begin op = OP_OR;   writes = 1'b1; useImm = 1'b1; dest = rt; end
            6'h0F: begin op = OP_LUI;  writes = 1'b1; useImm = 1'b1; dest = rt; end
            default: ;
        endcase
    end

    assign imm = signExt ? {{(`DATA_W-16){instrD_i[15]}}, instrD_i[15:0]}
                         : {{(`DATA_W-16){1'b0}}, instrD_i[15:0]};

    // youngest producer wins: execute, then writeback, then the file
    function automatic logic [`DATA_W-1:0] pickSrc(input logic [`REG_ADDR_W-1:0] r,
                                                  input logic [`DATA_W-1:0] rfData);
        if (r == '0)
            return '0;
        if (exFwdValid_i && exFwdReg_i == r)
            return exFwdData_i;
        if (wb.valid && wb.regWrite && wb.writeReg == r)
            return wb.data;
        return rfData;
    endfunction

    assign srcA = pickSrc(rs, rdataA_i);
    assign srcB = useImm ? imm : pickSrc(rt, rdataB_i);

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            de.valid    <= 1'b0;
            de.op       <= OP_NOP;
            de.regWrite <= 1'b0;
        end else if (!stall_i) begin
            de.valid    <= validD_i;
            de.op       <= op;
            de.regWrite <= writes && (dest != '0);  // r0 target never writes
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            de.pc       <= pcD_i;
            de.srcA     <= srcA;
            de.srcB     <= srcB;
            de.shamt    <= instrD_i[10:6];
            de.writeReg <= dest;
        end
    end

endmodule

// File: divFsm.sv
`include "core_consts.svh"

module divFsm (
    input  logic clk,
    input  logic rstN_i,
    input  logic divReq_i,
    output logic divStart_o,
    output logic divStep_o,
    output logic stall_o
);
    import corePkg::*;

    localparam int CNT_W = $clog2(`DIV_STEPS);

    divState_t          state;
    logic [CNT_W-1:0]   stepCnt;
    logic               lastStep;

    assign lastStep   = (stepCnt == CNT_W'(`DIV_STEPS - 1));
    assign divStart_o = (state == DIV_IDLE) && divReq_i;
    assign divStep_o  = (state == DIV_BUSY);

    // hold the front from the start cycle up to, not including, the last step
    assign stall_o = divStart_o || (divStep_o && !lastStep);

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            state   <= DIV_IDLE;
            stepCnt <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    stepCnt <= '0;
                    if (divReq_i)
                        state <= DIV_BUSY;
                end
                DIV_BUSY: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (lastStep)
                        state <= DIV_IDLE;  // DIVU leaves execute this cycle
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

endmodule

// File: divUnit.sv
`include "core_consts.svh"

module divUnit (
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                divStart_i,
    input  logic                divStep_i,
    input  logic [`DATA_W-1:0]  divA_i,
    input  logic [`DATA_W-1:0]  divB_i,
    output logic [`DATA_W-1:0]  hi_o,
    output logic [`DATA_W-1:0]  lo_o
);
    logic [`DATA_W-1:0]  rem;      // becomes HI
    logic [`DATA_W-1:0]  quo;      // dividend shifts out, quotient shifts in
    logic [`DATA_W-1:0]  divisor;
    logic [`DATA_W:0]    shifted;
    logic [`DATA_W:0]    diff;

    assign shifted = {rem, quo[`DATA_W-1]};
    assign diff    = shifted - {1'b0, divisor};

    // restoring step, a zero divisor always fits so it yields all ones
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            rem <= '0;
            quo <= '0;
        end else if (divStart_i) begin
            rem <= '0;
            quo <= divA_i;
        end else if (divStep_i) begin
            if (!diff[`DATA_W]) begin
                rem <= diff[`DATA_W-1:0];
                quo <= {quo[`DATA_W-2:0], 1'b1};
            end else begin
                rem <= shifted[`DATA_W-1:0];
                quo <= {quo[`DATA_W-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divStart_i)
            divisor <= divB_i;
    end

    assign hi_o = rem;
    assign lo_o = quo;

endmodule

// File: executeUnit.sv
`include "core_consts.svh"

module executeUnit (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    stall_i,
    deBus.slave                     de,
    input  logic [`DATA_W-1:0]      hi_i,
    input  logic [`DATA_W-1:0]      lo_i,
    output logic                    divReq_o,
    output logic [`DATA_W-1:0]      divA_o,
    output logic [`DATA_W-1:0]      divB_o,
    output logic                    exFwdValid_o,
    output logic [`REG_ADDR_W-1:0]  exFwdReg_o,
    output logic [`DATA_W-1:0]      exFwdData_o,
    wbBus.master                    wb
);
    import corePkg::*;

    localparam int HALF_W = `DATA_W / 2;

    logic [`DATA_W-1:0] result;

    always_comb begin
        case (de.op)
            OP_ADDU: result = de.srcA + de.srcB;  // wraps, no overflow trap
            OP_SUBU: result = de.srcA - de.srcB;
            OP_AND:  result = de.srcA & de.srcB;
            OP_OR:   result = de.srcA | de.srcB;
            OP_XOR:  result = de.srcA ^ de.srcB;
            OP_SLT:  result = ($signed(de.srcA) < $signed(de.srcB)) ? `DATA_W'(1) : '0;
            OP_SLL:  result = de.srcB << de.shamt;
            OP_LUI:  result = {de.srcB[HALF_W-1:0], {HALF_W{1'b0}}};
            OP_MFHI: result = hi_i;
            OP_MFLO: result = lo_i;
            default: result = '0;  // NOP and DIVU
        endcase
    end

    // divider hookup
    assign divReq_o = de.valid && (de.op == OP_DIVU);
    assign divA_o   = de.srcA;
    assign divB_o   = de.srcB;

    assign exFwdValid_o = de.valid && de.regWrite;
    assign exFwdReg_o   = de.writeReg;
    assign exFwdData_o  = result;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            wb.valid    <= 1'b0;
            wb.regWrite <= 1'b0;
        end else begin
            wb.valid    <= de.valid && !stall_i;  // bubble while the divider runs
            wb.regWrite <= de.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wb.pc       <= de.pc;
        wb.writeReg <= de.writeReg;
        wb.data     <= result;
    end

endmodule

// File: fetchUnit.sv
`include "core_consts.svh"

module fetchUnit (
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                stall_i,
    input  logic [`DATA_W-1:0]  instr_i,
    output logic [`DATA_W-1:0]  pc_o,
    output logic                instEn_o,
    output logic [`DATA_W-1:0]  instrD_o,
    output logic [`DATA_W-1:0]  pcD_o,
    output logic                validD_o
);
    assign instEn_o = ~stall_i;  // no fetch while the divider holds the front

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pc_o     <= `RESET_PC;
            validD_o <= 1'b0;
        end else if (!stall_i) begin
            pc_o     <= pc_o + `DATA_W'(4);
            validD_o <= 1'b1;
        end
    end

    // fetch to decode payload
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            instrD_o <= instr_i;
            pcD_o    <= pc_o;
        end
    end

endmodule

// File: mipsLite.sv
`include "core_consts.svh"

module mipsLite (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic [`DATA_W-1:0]      instr_i,
    output logic [`DATA_W-1:0]      pc_o,
    output logic                    instEn_o,
    output logic [`DATA_W-1:0]      wbPc_o,
    output logic                    wbRfWen_o,
    output logic [`REG_ADDR_W-1:0]  wbRfWnum_o,
    output logic [`DATA_W-1:0]      wbRfWdata_o,
    output logic                    commit_o
);
    logic                    stall;
    logic [`DATA_W-1:0]      instrD, pcD;
    logic                    validD;
    logic [`REG_ADDR_W-1:0]  raddrA, raddrB;
    logic [`DATA_W-1:0]      rdataA, rdataB;
    logic                    exFwdValid;
    logic [`REG_ADDR_W-1:0]  exFwdReg;
    logic [`DATA_W-1:0]      exFwdData;
    logic                    divReq, divStart, divStep;
    logic [`DATA_W-1:0]      divA, divB, hi, lo;

    deBus deIf ();
    wbBus wbIf ();

    fetchUnit uFetch (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stall), .instr_i(instr_i),
        .pc_o(pc_o), .instEn_o(instEn_o),
        .instrD_o(instrD), .pcD_o(pcD), .validD_o(validD)
    );

    regFile uRegFile (
        .clk(clk), .rstN_i(rstN_i), .raddrA_i(raddrA), .raddrB_i(raddrB),
        .rdataA_o(rdataA), .rdataB_o(rdataB), .wb(wbIf.slave)
    );

    decodeUnit uDecode (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stall),
        .instrD_i(instrD), .pcD_i(pcD), .validD_i(validD),
        .rdataA_i(rdataA), .rdataB_i(rdataB), .raddrA_o(raddrA), .raddrB_o(raddrB),
        .exFwdValid_i(exFwdValid), .exFwdReg_i(exFwdReg), .exFwdData_i(exFwdData),
        .wb(wbIf.slave), .de(deIf.master)
    );

    executeUnit uExecute (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stall), .de(deIf.slave),
        .hi_i(hi), .lo_i(lo), .divReq_o(divReq), .divA_o(divA), .divB_o(divB),
        .exFwdValid_o(exFwdValid), .exFwdReg_o(exFwdReg), .exFwdData_o(exFwdData),
        .wb(wbIf.master)
    );

    divFsm uDivFsm (
        .clk(clk), .rstN_i(rstN_i), .divReq_i(divReq),
        .divStart_o(divStart), .divStep_o(divStep), .stall_o(stall)
    );

    divUnit uDivUnit (
        .clk(clk), .rstN_i(rstN_i), .divStart_i(divStart), .divStep_i(divStep),
        .divA_i(divA), .divB_i(divB), .hi_o(hi), .lo_o(lo)
    );

    // debug view of the retiring instruction
    assign wbPc_o      = wbIf.pc;
    assign wbRfWen_o   = wbIf.valid & wbIf.regWrite;
    assign wbRfWnum_o  = wbIf.writeReg;
    assign wbRfWdata_o = wbIf.data;
    assign commit_o    = wbIf.valid;

endmodule

// File: regFile.sv
`include "core_consts.svh"

module regFile (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic [`REG_ADDR_W-1:0]  raddrA_i,
    input  logic [`REG_ADDR_W-1:0]  raddrB_i,
    output logic [`DATA_W-1:0]      rdataA_o,
    output logic [`DATA_W-1:0]      rdataB_o,
    wbBus.slave                     wb
);
    logic [`DATA_W-1:0] regs [`REG_COUNT];
    logic               wrEn;

    assign wrEn = wb.valid && wb.regWrite && (wb.writeReg != '0);  // r0 stays zero

    // same-cycle write shows up on the read port
    function automatic logic [`DATA_W-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
        if (wrEn && wb.writeReg == addr)
            return wb.data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wrEn) begin
            regs[wb.writeReg] <= wb.data;
        end
    end

    assign rdataA_o = readPort(raddrA_i);
    assign rdataB_o = readPort(raddrB_i);

endmodule

// File: stageIf.sv
`include "core_consts.svh"

// decode to execute bundle
interface deBus;
    import corePkg::*;

    logic                        valid;
    logic [`DATA_W-1:0]          pc;
    aluOp_t                      op;
    logic [`DATA_W-1:0]          srcA;
    logic [`DATA_W-1:0]          srcB;     // immediate already muxed in
    logic [$clog2(`DATA_W)-1:0]  shamt;
    logic [`REG_ADDR_W-1:0]      writeReg;
    logic                        regWrite;

    modport master (output valid, pc, op, srcA, srcB, shamt, writeReg, regWrite);
    modport slave  (input  valid, pc, op, srcA, srcB, shamt, writeReg, regWrite);
endinterface

// writeback bundle, feeds the register file, forwarding and debug ports
interface wbBus;
    logic                    valid;
    logic [`DATA_W-1:0]      pc;
    logic [`REG_ADDR_W-1:0]  writeReg;
    logic                    regWrite;
    logic [`DATA_W-1:0]      data;

    modport master (output valid, pc, writeReg, regWrite, data);
    modport slave  (input  valid, pc, writeReg, regWrite, data);
endinterface

// File: tbMipsLite.sv
`include "core_consts.svh"

module tbMipsLite;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int PROG_LEN        = 200;
    localparam int ROM_WORDS       = 256;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 40 + RESET_CYCLES;

    // K_ADDU..K_LUI map straight from a random pick so their order matters
    typedef enum int {
        K_ADDU, K_SUBU, K_AND, K_OR, K_XOR, K_SLT, K_SLL, K_ADDIU, K_ORI, K_LUI,
        K_DIVU, K_MFHI, K_MFLO, K_NOP, K_BAD
    } kind_t;

    logic                    clk;
    logic                    rstN;
    logic [`DATA_W-1:0]      instr;
    logic [`DATA_W-1:0]      pc;
    logic                    instEn;
    logic [`DATA_W-1:0]      wbPc;
    logic                    wbRfWen;
    logic [`REG_ADDR_W-1:0]  wbRfWnum;
    logic [`DATA_W-1:0]      wbRfWdata;
    logic                    commit;

    // program image and expected retirement per slot
    logic [31:0]  rom      [ROM_WORDS];
    kind_t        progKind [ROM_WORDS];
    logic         expWen   [ROM_WORDS];
    logic [4:0]   expReg   [ROM_WORDS];
    logic [31:0]  expData  [ROM_WORDS];

    logic [31:0]  mreg [32];  // architectural state of the model
    logic [31:0]  hiModel;
    logic [31:0]  loModel;
    integer       seed;

    int           commitCount   = 0;
    logic         stalledBefore = 1'b0;
    logic         divSeen       = 1'b0;  // stall observed since the last commit
    logic [31:0]  romIdx;

    mipsLite UUT (
        .clk(clk), .rstN_i(rstN), .instr_i(instr), .pc_o(pc), .instEn_o(instEn),
        .wbPc_o(wbPc), .wbRfWen_o(wbRfWen), .wbRfWnum_o(wbRfWnum),
        .wbRfWdata_o(wbRfWdata), .commit_o(commit)
    );

    assign romIdx = (pc - `RESET_PC) >> 2;
    assign instr  = (romIdx < 32'(ROM_WORDS)) ? rom[romIdx[7:0]] : '0;  // NOPs past the end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkHex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else abortRun($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] encodeInst(input kind_t k, input logic [4:0] rs, rt, rd, sh,
                                               input logic [15:0] imm);
        case (k)
            K_ADDU:  return {6'h00, rs, rt, rd, 5'd0, 6'h21};
            K_SUBU:  return {6'h00, rs, rt, rd, 5'd0, 6'h23};
            K_AND:   return {6'h00, rs, rt, rd, 5'd0, 6'h24};
            K_OR:    return {6'h00, rs, rt, rd, 5'd0, 6'h25};
            K_XOR:   return {6'h00, rs, rt, rd, 5'd0, 6'h26};
            K_SLT:   return {6'h00, rs, rt, rd, 5'd0, 6'h2A};
            K_SLL:   return {6'h00, 5'd0, rt, rd, sh, 6'h00};
            K_ADDIU: return {6'h09, rs, rt, imm};
            K_ORI:   return {6'h0D, rs, rt, imm};
            K_LUI:   return {6'h0F, 5'd0, rt, imm};
            K_DIVU:  return {6'h00, rs, rt, 10'd0, 6'h1B};
            K_MFHI:  return {6'h00, 10'd0, rd, 5'd0, 6'h10};
            K_MFLO:  return {6'h00, 10'd0, rd, 5'd0, 6'h12};
            K_BAD:   return {6'h3F, rs, rt, imm};  // undefined opcode
            default: return '0;
        endcase
    endfunction

    // places one instruction and runs it through the in-order model
    task automatic emitInstr(input logic [7:0] slot, input kind_t k,
                             input logic [4:0] rs, rt, rd, sh, input logic [15:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  dest;
        a    = mreg[rs];
        b    = mreg[rt];
        res  = '0;
        dest = (k inside {K_ADDIU, K_ORI, K_LUI}) ? rt : rd;
        case (k)
            K_ADDU:  res = a + b;
            K_SUBU:  res = a - b;
            K_AND:   res = a & b;
            K_OR:    res = a | b;
            K_XOR:   res = a ^ b;
            K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_SLL:   res = b << sh;
            K_ADDIU: res = a + {{16{imm[15]}}, imm};
            K_ORI:   res = a | {16'h0000, imm};
            K_LUI:   res = {imm, 16'h0000};
            K_MFHI:  res = hiModel;
            K_MFLO:  res = loModel;
            K_DIVU: begin
                // zero divisor gives all ones and keeps the dividend as remainder
                loModel = (b == 0) ? 32'hFFFF_FFFF : a / b;
                hiModel = (b == 0) ? a : a % b;
            end
            default: res = '0;
        endcase
        rom[slot]      = encodeInst(k, rs, rt, rd, sh, imm);
        progKind[slot] = k;
        expWen[slot]   = !(k inside {K_DIVU, K_NOP, K_BAD}) && (dest != 5'd0);
        expReg[slot]   = dest;
        expData[slot]  = res;
        if (expWen[slot])
            mreg[dest] = res;
    endtask

    task automatic buildProgram();
        int         i;
        int         r;
        int         divCount;
        kind_t      k;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        seed     = 29;
        rom      = '{default: '0};
        progKind = '{default: K_NOP};
        expWen   = '{default: 1'b0};
        expReg   = '{default: '0};
        expData  = '{default: '0};
        mreg     = '{default: '0};
        hiModel  = '0;
        loModel  = '0;
        i        = 0;
        divCount = 0;
        while (i < PROG_LEN) begin
            rs = 5'($random(seed) & 7);  // r0..r7 keeps dependencies dense
            rt = 5'($random(seed) & 7);
            rd = 5'($random(seed) & 7);
            if (i % 20 == 9) begin
                if (divCount % 3 == 0)
                    rt = 5'd0;  // divide by zero
                emitInstr(8'(i), K_DIVU, rs, rt, 5'd0, 5'd0, 16'h0000);
                emitInstr(8'(i + 1), K_MFHI, 5'd0, 5'd0, rd, 5'd0, 16'h0000);
                emitInstr(8'(i + 2), K_MFLO, 5'd0, 5'd0, 5'($random(seed) & 7), 5'd0, 16'h0000);
                divCount++;
                i += 3;
            end else begin
                r = $unsigned($random(seed)) % 12;
                if (r < 10)
                    k = kind_t'(r);
                else
                    k = (r == 10) ? K_ADDIU : K_BAD;  // more ADDIU plus undefined opcodes
                emitInstr(8'(i), k, rs, rt, rd, 5'($random(seed)), 16'($random(seed)));
                i++;
            end
        end
    endtask

    task automatic checkCommit();
        logic [7:0] slot;
        slot = 8'(commitCount);
        checkHex("wbPc_o", wbPc, `RESET_PC + 32'(commitCount * 4));
        checkHex("wbRfWen_o", 32'(wbRfWen), 32'(expWen[slot]));
        if (expWen[slot]) begin
            checkHex("wbRfWnum_o", 32'(wbRfWnum), 32'(expReg[slot]));
            checkHex("wbRfWdata_o", wbRfWdata, expData[slot]);
        end
        assert (divSeen == (progKind[slot] == K_DIVU))
        else abortRun($sformatf("stall and divide do not line up at instruction %0d",
                                commitCount));
        divSeen = 1'b0;
        commitCount++;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abortRun("timeout, the program did not finish retiring in time");
    end

    // falling edge, between the DUT updates
    always @(negedge clk) begin
        if (!rstN) begin
            assert (!commit && !wbRfWen)
            else abortRun("a commit or register write appeared during reset");
            stalledBefore = 1'b0;
            divSeen       = 1'b0;
        end else begin
            if (stalledBefore) begin
                // DIVU is the next to retire, fetch sits two slots behind it
                checkHex("pc_o", pc, `RESET_PC + 32'((commitCount + 2) * 4));
                assert (!commit)
                else abortRun("an instruction retired while a divide was in progress");
            end
            if (commit)
                checkCommit();
            if (!instEn)
                divSeen = 1'b1;
            stalledBefore = !instEn;
        end
    end

    initial begin
        buildProgram();
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        while (commitCount < PROG_LEN)
            @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule
